// File: sources.f
+incdir+design
design/order_book_pkg.sv
design/book_side_mem.sv
design/best_price_cache.sv
design/order_book_ctrl.sv
design/order_book.sv
verification/order_book_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the order book testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module order_book_tb \
    -f sources.f -o order_book_sim \
    && ./obj_dir/order_book_sim | tee /dev/stderr | grep -qx "all tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verification/order_book_tb.sv
/* order book testbench */
`timescale 1ns/100ps
`include "order_book_cfg.svh"

module order_book_tb
    import order_book_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 10;
    localparam int DEPTH         = `OB_BOOK_DEPTH;
    localparam int DIRECTED_MSGS = 27;
    localparam int RANDOM_MSGS   = 300;
    // full search, shift, full rescan and respond, plus the wait for idle
    localparam int MAX_LATENCY   = 2 * DEPTH + 6;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + (DIRECTED_MSGS + RANDOM_MSGS) * MAX_LATENCY + 200;
    localparam logic [31:0] SEED = 32'hb91baecd;

    logic          i_clk;
    logic          i_reset_n;
    logic          i_order_valid;
    order_msg_t    i_order;
    logic          o_book_is_busy;
    logic          o_data_valid;
    ob_result_t    o_result;

    // reference book, side index 1 holds the bid list
    book_entry_t               model_list [2][`OB_NUM_STOCKS][DEPTH];
    int                        model_cnt  [2][`OB_NUM_STOCKS];
    logic [`OB_PRICE_W-1:0]    model_last;

    ob_result_t                exp_q [$];
    string                     test_name;
    int                        sent_count;
    int                        rx_count;
    int                        check_count;
    int                        error_count;

    order_book i_dut (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_order_valid  (i_order_valid),
        .i_order        (i_order),
        .o_book_is_busy (o_book_is_busy),
        .o_data_valid   (o_data_valid),
        .o_result       (o_result)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            i_clk = ~i_clk;
        end
    end

    function automatic order_msg_t make_order(order_kind_e kind, side_e side, int stock,
                                              int qty, int price, int id);
        order_msg_t m;
        m.kind  = kind;
        m.side  = side;
        m.stock = `OB_STOCK_W'(stock);
        m.qty   = `OB_QTY_W'(qty);
        m.price = `OB_PRICE_W'(price);
        m.id    = `OB_ID_W'(id);
        return m;
    endfunction

    function automatic void remove_entry(int sd, int s, int slot);
        for (int j = slot; j < model_cnt[sd][s] - 1; j++) begin
            model_list[sd][s][j] = model_list[sd][s][j + 1];
        end
        model_cnt[sd][s]--;
    endfunction

    // empty bid reads 0, empty ask reads all ones
    function automatic logic [`OB_PRICE_W-1:0] best_price_of(int sd, int s);
        logic [`OB_PRICE_W-1:0] best;
        best = (sd == 1) ? {`OB_PRICE_W{1'b0}} : {`OB_PRICE_W{1'b1}};
        for (int j = 0; j < model_cnt[sd][s]; j++) begin
            if (sd == 1 && model_list[sd][s][j].price > best) begin
                best = model_list[sd][s][j].price;
            end else if (sd == 0 && model_list[sd][s][j].price < best) begin
                best = model_list[sd][s][j].price;
            end
        end
        return best;
    endfunction

    function automatic ob_result_t model_apply(order_msg_t m);
        ob_result_t  r;
        book_entry_t e;
        int          s;
        int          sd;
        int          slot;
        bit          found;
        s        = int'(m.stock);
        sd       = (m.side == SIDE_BUY) ? 1 : 0;
        slot     = 0;
        found    = 1'b0;
        r.status = OB_OK;
        if (m.kind == ORD_ADD) begin
            if (model_cnt[sd][s] == DEPTH) begin
                r.status = OB_FULL;
            end else begin
                e.qty   = m.qty;
                e.price = m.price;
                e.id    = m.id;
                model_list[sd][s][model_cnt[sd][s]] = e;
                model_cnt[sd][s]++;
            end
        end else begin
            // both lists are searched slot by slot, bid before ask at each slot
            for (int j = 0; j < DEPTH && !found; j++) begin
                for (int k = 1; k >= 0 && !found; k--) begin
                    if (j < model_cnt[k][s] && model_list[k][s][j].id == m.id) begin
                        found = 1'b1;
                        sd    = k;
                        slot  = j;
                    end
                end
            end
            if (!found) begin
                r.status = OB_NOT_FOUND;
            end else begin
                e = model_list[sd][s][slot];
                if (m.kind == ORD_EXECUTE) begin
                    model_last = m.price;
                end
                if (m.kind == ORD_CANCEL || e.qty <= m.qty) begin
                    remove_entry(sd, s, slot);
                end else begin
                    model_list[sd][s][slot].qty = e.qty - m.qty;
                end
            end
        end
        r.stock      = m.stock;
        r.best_bid   = best_price_of(1, s);
        r.best_ask   = best_price_of(0, s);
        r.last_price = model_last;
        return r;
    endfunction

    task automatic check_field(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("** Error %s: %s expected %0h actual %0h",
                     test_name, field, expected, actual);
        end
    endtask

    // compare every result pulse with the oldest expected result
    always @(negedge i_clk) begin : compare_results
        ob_result_t exp_r;
        if (i_reset_n && o_data_valid) begin
            rx_count++;
            if (exp_q.size() == 0) begin
                error_count++;
                $display("a result pulse arrived with no order outstanding at %0t", $time);
            end else begin
                exp_r = exp_q.pop_front();
                check_field("stock", exp_r.stock, o_result.stock);
                check_field("status", exp_r.status, o_result.status);
                check_field("best_bid", exp_r.best_bid, o_result.best_bid);
                check_field("best_ask", exp_r.best_ask, o_result.best_ask);
                check_field("last_price", exp_r.last_price, o_result.last_price);
                check_field("busy_at_done", 64'd0, o_book_is_busy);
            end
        end
    end

    // called a drive delay after a rising edge, returns at the same point
    task automatic send_order(input order_msg_t m);
        while (o_book_is_busy) begin
            @(posedge i_clk);
            #DRIVE_DELAY;
        end
        exp_q.push_back(model_apply(m));
        i_order       = m;
        i_order_valid = 1'b1;
        @(posedge i_clk);
        #DRIVE_DELAY;
        i_order_valid = 1'b0;
        sent_count++;
    endtask

    task automatic drain_results();
        while (rx_count < sent_count) begin
            @(posedge i_clk);
        end
        #DRIVE_DELAY;
    endtask

    task automatic check_empty_books();
        test_name = "empty_books";
        for (int s = 0; s < `OB_NUM_STOCKS; s++) begin
            send_order(make_order(ORD_CANCEL, SIDE_BUY, s, 0, 0, 32'h0dead000 + s));
        end
        drain_results();
    endtask

    task automatic build_books();
        test_name = "build_books";
        send_order(make_order(ORD_ADD, SIDE_BUY, 0, 10, 100, 1));
        send_order(make_order(ORD_ADD, SIDE_BUY, 0, 10, 105, 2));
        send_order(make_order(ORD_ADD, SIDE_BUY, 0, 10, 102, 3));
        send_order(make_order(ORD_ADD, SIDE_SELL, 0, 10, 110, 4));
        send_order(make_order(ORD_ADD, SIDE_SELL, 0, 10, 108, 5));
        send_order(make_order(ORD_ADD, SIDE_SELL, 0, 10, 112, 6));
        send_order(make_order(ORD_ADD, SIDE_BUY, 1, 10, 50, 7));
        send_order(make_order(ORD_ADD, SIDE_BUY, 1, 10, 55, 8));
        send_order(make_order(ORD_ADD, SIDE_SELL, 1, 10, 60, 9));
        drain_results();
    endtask

    task automatic cancel_best_and_middle();
        test_name = "cancel_best_and_middle";
        // 105 is the best bid, 110 sits between 108 and 112
        send_order(make_order(ORD_CANCEL, SIDE_BUY, 0, 0, 0, 2));
        send_order(make_order(ORD_CANCEL, SIDE_SELL, 0, 0, 0, 4));
        drain_results();
    endtask

    task automatic execute_partial_and_full();
        test_name = "execute_partial_and_full";
        send_order(make_order(ORD_EXECUTE, SIDE_BUY, 1, 4, 54, 8));
        send_order(make_order(ORD_EXECUTE, SIDE_BUY, 1, 6, 53, 8));
        drain_results();
    endtask

    task automatic overflow_one_side();
        test_name = "overflow_one_side";
        for (int k = 0; k <= DEPTH; k++) begin
            send_order(make_order(ORD_ADD, SIDE_BUY, 2, 5, 200 + k, 100 + k));
        end
        // the rejected order must not be in the book
        send_order(make_order(ORD_CANCEL, SIDE_BUY, 2, 0, 0, 100 + DEPTH));
        drain_results();
    endtask

    task automatic random_mix(input int n);
        order_msg_t m;
        int         pick;
        test_name = "random_mix";
        for (int k = 0; k < n; k++) begin
            pick    = int'($urandom_range(3, 0));
            m.stock = `OB_STOCK_W'($urandom_range(`OB_NUM_STOCKS - 1, 0));
            m.side  = ($urandom_range(1, 0) == 1) ? SIDE_BUY : SIDE_SELL;
            m.id    = `OB_ID_W'($urandom_range(24, 1));
            m.price = `OB_PRICE_W'($urandom_range(220, 180));
            if (pick < 2) begin
                m.kind = ORD_ADD;
                m.qty  = `OB_QTY_W'($urandom_range(100, 1));
            end else if (pick == 2) begin
                m.kind = ORD_CANCEL;
                m.qty  = '0;
            end else begin
                m.kind = ORD_EXECUTE;
                m.qty  = `OB_QTY_W'($urandom_range(60, 1));
            end
            send_order(m);
        end
        drain_results();
    endtask

    initial begin : watchdog
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("watchdog expired with %0d of %0d results received", rx_count, sent_count);
        $display("tests failed");
        $finish;
    end

    initial begin
        i_reset_n     = 1'b0;
        i_order_valid = 1'b0;
        i_order       = '0;
        model_last    = '0;
        sent_count    = 0;
        rx_count      = 0;
        check_count   = 0;
        error_count   = 0;
        test_name     = "reset";
        for (int k = 0; k < 2; k++) begin
            for (int s = 0; s < `OB_NUM_STOCKS; s++) begin
                model_cnt[k][s] = 0;
            end
        end
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge i_clk);
        #DRIVE_DELAY;
        i_reset_n = 1'b1;
        @(posedge i_clk);
        #DRIVE_DELAY;

        check_empty_books();
        build_books();
        cancel_best_and_middle();
        execute_partial_and_full();
        overflow_one_side();
        random_mix(RANDOM_MSGS);

        $display("results %0d of %0d, checks %0d, errors %0d",
                 rx_count, sent_count, check_count, error_count);
        if (error_count == 0 && rx_count == sent_count) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: design/order_book.sv
/* limit order book top */
`timescale 1ns/100ps
`include "order_book_cfg.svh"

module order_book
    import order_book_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset_n,
    input  logic        i_order_valid,
    input  order_msg_t  i_order,
    output logic        o_book_is_busy,
    output logic        o_data_valid,
    output ob_result_t  o_result
);

    logic [`OB_STOCK_W-1:0]    stock;
    logic [`OB_SLOT_W-1:0]     slot;
    side_e                     side;
    logic                      append_bid;
    logic                      append_ask;
    logic                      update_bid;
    logic                      update_ask;
    logic                      remove_bid;
    logic                      remove_ask;
    book_entry_t               wr_entry;
    book_entry_t               bid_entry;
    book_entry_t               ask_entry;
    logic [`OB_CNT_W-1:0]      bid_count;
    logic [`OB_CNT_W-1:0]      ask_count;
    logic                      bid_full;
    logic                      ask_full;
    logic                      cache_add;
    logic                      cache_load;
    logic [`OB_PRICE_W-1:0]    cache_price;
    logic [`OB_PRICE_W-1:0]    best_bid;
    logic [`OB_PRICE_W-1:0]    best_ask;

    order_book_ctrl u_ctrl (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_order_valid  (i_order_valid),
        .i_order        (i_order),
        .i_bid_entry    (bid_entry),
        .i_ask_entry    (ask_entry),
        .i_bid_count    (bid_count),
        .i_ask_count    (ask_count),
        .i_bid_full     (bid_full),
        .i_ask_full     (ask_full),
        .i_best_bid     (best_bid),
        .i_best_ask     (best_ask),
        .o_stock        (stock),
        .o_slot         (slot),
        .o_side         (side),
        .o_append_bid   (append_bid),
        .o_append_ask   (append_ask),
        .o_update_bid   (update_bid),
        .o_update_ask   (update_ask),
        .o_remove_bid   (remove_bid),
        .o_remove_ask   (remove_ask),
        .o_entry        (wr_entry),
        .o_cache_add    (cache_add),
        .o_cache_load   (cache_load),
        .o_cache_price  (cache_price),
        .o_book_is_busy (o_book_is_busy),
        .o_data_valid   (o_data_valid),
        .o_result       (o_result)
    );

    // buy side list
    book_side_mem u_bid_mem (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_stock   (stock),
        .i_slot    (slot),
        .i_append  (append_bid),
        .i_update  (update_bid),
        .i_remove  (remove_bid),
        .i_entry   (wr_entry),
        .o_entry   (bid_entry),
        .o_count   (bid_count),
        .o_full    (bid_full)
    );

    // sell side list
    book_side_mem u_ask_mem (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_stock   (stock),
        .i_slot    (slot),
        .i_append  (append_ask),
        .i_update  (update_ask),
        .i_remove  (remove_ask),
        .i_entry   (wr_entry),
        .o_entry   (ask_entry),
        .o_count   (ask_count),
        .o_full    (ask_full)
    );

    best_price_cache u_cache (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_stock    (stock),
        .i_side     (side),
        .i_add      (cache_add),
        .i_load     (cache_load),
        .i_price    (cache_price),
        .o_best_bid (best_bid),
        .o_best_ask (best_ask)
    );

endmodule

// File: design/order_book_ctrl.sv
/* order book sequencer */
`timescale 1ns/100ps
`include "order_book_cfg.svh"

module order_book_ctrl
    import order_book_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_order_valid,
    input  order_msg_t              i_order,
    input  book_entry_t             i_bid_entry,
    input  book_entry_t             i_ask_entry,
    input  logic [`OB_CNT_W-1:0]    i_bid_count,
    input  logic [`OB_CNT_W-1:0]    i_ask_count,
    input  logic                    i_bid_full,
    input  logic                    i_ask_full,
    input  logic [`OB_PRICE_W-1:0]  i_best_bid,
    input  logic [`OB_PRICE_W-1:0]  i_best_ask,
    output logic [`OB_STOCK_W-1:0]  o_stock,
    output logic [`OB_SLOT_W-1:0]   o_slot,
    output side_e                   o_side,
    output logic                    o_append_bid,
    output logic                    o_append_ask,
    output logic                    o_update_bid,
    output logic                    o_update_ask,
    output logic                    o_remove_bid,
    output logic                    o_remove_ask,
    output book_entry_t             o_entry,
    output logic                    o_cache_add,
    output logic                    o_cache_load,
    output logic [`OB_PRICE_W-1:0]  o_cache_price,
    output logic                    o_book_is_busy,
    output logic                    o_data_valid,
    output ob_result_t              o_result
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADD,
        S_SEARCH,
        S_SHIFT,
        S_RESCAN,
        S_RESPOND
    } state_e;

    state_e                    state_q;
    order_msg_t                msg_q;
    side_e                     side_q;
    logic [`OB_CNT_W-1:0]      ptr_q;
    logic [`OB_PRICE_W-1:0]    best_q;
    logic [`OB_PRICE_W-1:0]    last_price_q;
    ob_result_t                result_q;

    logic                      waiting;
    logic                      accept;
    logic                      accept_full;
    logic                      is_buy;
    logic                      hit_bid;
    logic                      hit_ask;
    logic                      search_done;
    logic                      fill_done;
    logic                      scan_last;
    logic [`OB_CNT_W-1:0]      ptr_next;
    logic [`OB_CNT_W-1:0]      max_count;
    logic [`OB_CNT_W-1:0]      side_count;
    book_entry_t               side_entry;
    logic [`OB_PRICE_W-1:0]    scan_best;
    logic [`OB_PRICE_W-1:0]    empty_price;
    logic [`OB_PRICE_W-1:0]    add_bid;
    logic [`OB_PRICE_W-1:0]    add_ask;

    assign waiting     = (state_q == S_IDLE) || (state_q == S_RESPOND);
    assign accept      = i_order_valid && waiting;
    assign accept_full = (i_order.side == SIDE_BUY) ? i_bid_full : i_ask_full;

    // while waiting the incoming stock is presented, so its full flag is ready at accept
    assign o_stock = waiting ? i_order.stock : msg_q.stock;
    assign o_slot  = ptr_q[`OB_SLOT_W-1:0];
    assign o_side  = side_q;

    assign is_buy     = (side_q == SIDE_BUY);
    assign side_entry = is_buy ? i_bid_entry : i_ask_entry;
    assign side_count = is_buy ? i_bid_count : i_ask_count;
    assign max_count  = (i_bid_count > i_ask_count) ? i_bid_count : i_ask_count;
    assign ptr_next   = ptr_q + 1'b1;

    // bid and ask lists are searched at the same slot in one cycle, bid first
    assign hit_bid     = (ptr_q < i_bid_count) && (i_bid_entry.id == msg_q.id);
    assign hit_ask     = (ptr_q < i_ask_count) && (i_ask_entry.id == msg_q.id);
    assign search_done = (ptr_next >= max_count);

    // remaining quantity at or below zero removes the order
    assign fill_done = (msg_q.kind == ORD_CANCEL) || (side_entry.qty <= msg_q.qty);

    assign empty_price = is_buy ? {`OB_PRICE_W{1'b0}} : {`OB_PRICE_W{1'b1}};
    assign scan_last   = (ptr_next >= side_count);

    always_comb begin
        scan_best = best_q;
        if (ptr_q < side_count) begin
            if (is_buy ? (side_entry.price > best_q) : (side_entry.price < best_q)) begin
                scan_best = side_entry.price;
            end
        end
    end

    // cache contents after this add, for the result word
    assign add_bid = (is_buy && msg_q.price > i_best_bid) ? msg_q.price : i_best_bid;
    assign add_ask = (!is_buy && msg_q.price < i_best_ask) ? msg_q.price : i_best_ask;

    assign o_entry = (state_q == S_ADD) ? {msg_q.qty, msg_q.price, msg_q.id} :
                     {side_entry.qty - msg_q.qty, side_entry.price, side_entry.id};

    assign o_append_bid  = (state_q == S_ADD) && is_buy;
    assign o_append_ask  = (state_q == S_ADD) && !is_buy;
    assign o_update_bid  = (state_q == S_SHIFT) && is_buy && !fill_done;
    assign o_update_ask  = (state_q == S_SHIFT) && !is_buy && !fill_done;
    assign o_remove_bid  = (state_q == S_SHIFT) && is_buy && fill_done;
    assign o_remove_ask  = (state_q == S_SHIFT) && !is_buy && fill_done;
    assign o_cache_add   = (state_q == S_ADD);
    assign o_cache_load  = (state_q == S_RESCAN) && scan_last;
    assign o_cache_price = (state_q == S_ADD) ? msg_q.price : scan_best;

    assign o_book_is_busy = !waiting;
    assign o_data_valid   = (state_q == S_RESPOND);
    assign o_result       = result_q;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q      <= S_IDLE;
            last_price_q <= '0;
        end else begin
            case (state_q)
                S_IDLE, S_RESPOND: begin
                    state_q <= S_IDLE;
                    if (accept) begin
                        if (i_order.kind != ORD_ADD) begin
                            state_q <= S_SEARCH;
                        end else if (accept_full) begin
                            state_q <= S_RESPOND;
                        end else begin
                            state_q <= S_ADD;
                        end
                    end
                end
                S_ADD: state_q <= S_RESPOND;
                S_SEARCH: begin
                    if (hit_bid || hit_ask) begin
                        state_q <= S_SHIFT;
                        if (msg_q.kind == ORD_EXECUTE) begin
                            last_price_q <= msg_q.price;
                        end
                    end else if (search_done) begin
                        state_q <= S_RESPOND;
                    end
                end
                S_SHIFT: state_q <= S_RESCAN;
                S_RESCAN: begin
                    if (scan_last) begin
                        state_q <= S_RESPOND;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        case (state_q)
            S_IDLE, S_RESPOND: begin
                if (accept) begin
                    msg_q  <= i_order;
                    side_q <= i_order.side;
                    ptr_q  <= '0;
                    result_q <= {i_order.stock, OB_FULL, i_best_bid, i_best_ask, last_price_q};
                end
            end
            S_ADD: begin
                result_q <= {msg_q.stock, OB_OK, add_bid, add_ask, last_price_q};
            end
            S_SEARCH: begin
                if (hit_bid) begin
                    side_q <= SIDE_BUY;
                end else if (hit_ask) begin
                    side_q <= SIDE_SELL;
                end else begin
                    ptr_q    <= ptr_next;
                    result_q <= {msg_q.stock, OB_NOT_FOUND, i_best_bid, i_best_ask,
                                 last_price_q};
                end
            end
            S_SHIFT: begin
                ptr_q  <= '0;
                best_q <= empty_price;
            end
            S_RESCAN: begin
                ptr_q  <= ptr_next;
                best_q <= scan_best;
                if (is_buy) begin
                    result_q <= {msg_q.stock, OB_OK, scan_best, i_best_ask, last_price_q};
                end else begin
                    result_q <= {msg_q.stock, OB_OK, i_best_bid, scan_best, last_price_q};
                end
            end
            default: ;
        endcase
    end

    // rejected adds go straight to respond, so a full list is never appended
    no_append_when_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (o_append_bid |-> !i_bid_full) and (o_append_ask |-> !i_ask_full));

    // the search pointer stays inside the occupied slots of the longer list
    busy_during_search: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (state_q == S_SEARCH) |-> o_book_is_busy && (ptr_q == '0 || ptr_q < max_count));

endmodule

// File: design/best_price_cache.sv
/* best bid and ask cache */
`timescale 1ns/100ps
`include "order_book_cfg.svh"

module best_price_cache
    import order_book_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic [`OB_STOCK_W-1:0]  i_stock,
    input  side_e                   i_side,
    input  logic                    i_add,
    input  logic                    i_load,
    input  logic [`OB_PRICE_W-1:0]  i_price,
    output logic [`OB_PRICE_W-1:0]  o_best_bid,
    output logic [`OB_PRICE_W-1:0]  o_best_ask
);

    logic [`OB_PRICE_W-1:0]    bid_q [`OB_NUM_STOCKS];
    logic [`OB_PRICE_W-1:0]    ask_q [`OB_NUM_STOCKS];
    logic [`OB_PRICE_W-1:0]    cur_bid;
    logic [`OB_PRICE_W-1:0]    cur_ask;
    logic                      bid_wr;
    logic                      ask_wr;

    assign cur_bid = bid_q[i_stock];
    assign cur_ask = ask_q[i_stock];

    // a load takes the scanned price as is, an add only improves
    assign bid_wr = (i_side == SIDE_BUY) && (i_load || (i_add && i_price > cur_bid));
    assign ask_wr = (i_side == SIDE_SELL) && (i_load || (i_add && i_price < cur_ask));

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            // empty bid shows 0, empty ask shows all ones
            for (int s = 0; s < `OB_NUM_STOCKS; s++) begin
                bid_q[s] <= '0;
                ask_q[s] <= '1;
            end
        end else begin
            if (bid_wr) begin
                bid_q[i_stock] <= i_price;
            end
            if (ask_wr) begin
                ask_q[i_stock] <= i_price;
            end
        end
    end

    assign o_best_bid = cur_bid;
    assign o_best_ask = cur_ask;

endmodule

// File: design/book_side_mem.sv
/* single side order storage */
`timescale 1ns/100ps
`include "order_book_cfg.svh"

module book_side_mem
    import order_book_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic [`OB_STOCK_W-1:0]  i_stock,
    input  logic [`OB_SLOT_W-1:0]   i_slot,
    input  logic                    i_append,
    input  logic                    i_update,
    input  logic                    i_remove,
    input  book_entry_t             i_entry,
    output book_entry_t             o_entry,
    output logic [`OB_CNT_W-1:0]    o_count,
    output logic                    o_full
);

    localparam int DEPTH = `OB_BOOK_DEPTH;

    book_entry_t               mem_q   [`OB_NUM_STOCKS][DEPTH];
    logic [`OB_CNT_W-1:0]      count_q [`OB_NUM_STOCKS];
    logic [`OB_CNT_W-1:0]      cur_count;

    assign cur_count = count_q[i_stock];
    assign o_entry   = mem_q[i_stock][i_slot];
    assign o_count   = cur_count;
    assign o_full    = (cur_count == `OB_CNT_W'(DEPTH));

    // entries of a stock always sit in slots 0 to count-1
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int s = 0; s < `OB_NUM_STOCKS; s++) begin
                count_q[s] <= '0;
            end
        end else if (i_append && !o_full) begin
            count_q[i_stock] <= cur_count + 1'b1;
        end else if (i_remove) begin
            count_q[i_stock] <= cur_count - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_append && !o_full) begin
            mem_q[i_stock][cur_count[`OB_SLOT_W-1:0]] <= i_entry;
        end else if (i_update) begin
            // partial fill, only the quantity changes
            mem_q[i_stock][i_slot].qty <= i_entry.qty;
        end else if (i_remove) begin
            // close the gap, every later entry moves down one slot
            for (int j = 0; j < DEPTH - 1; j++) begin
                if (j >= int'(i_slot) && j + 1 < int'(cur_count)) begin
                    mem_q[i_stock][j] <= mem_q[i_stock][j + 1];
                end
            end
        end
    end

    remove_in_range: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_remove |-> ({1'b0, i_slot} < cur_count));

endmodule

// File: design/order_book_pkg.sv
/* order book types */
`include "order_book_cfg.svh"

package order_book_pkg;

    // logic high is a buy, as on the feed
    typedef enum logic {
        SIDE_SELL = 1'b0,
        SIDE_BUY  = 1'b1
    } side_e;

    typedef enum logic [1:0] {
        ORD_ADD     = 2'd0,
        ORD_CANCEL  = 2'd1,
        ORD_EXECUTE = 2'd2
    } order_kind_e;

    typedef struct packed {
        order_kind_e               kind;
        side_e                     side;
        logic [`OB_STOCK_W-1:0]    stock;
        logic [`OB_QTY_W-1:0]      qty;
        logic [`OB_PRICE_W-1:0]    price;
        logic [`OB_ID_W-1:0]       id;
    } order_msg_t;

    // one resting order in a side list
    typedef struct packed {
        logic [`OB_QTY_W-1:0]      qty;
        logic [`OB_PRICE_W-1:0]    price;
        logic [`OB_ID_W-1:0]       id;
    } book_entry_t;

    typedef enum logic [1:0] {
        OB_OK        = 2'd0,
        OB_NOT_FOUND = 2'd1,
        OB_FULL      = 2'd2
    } ob_status_e;

    typedef struct packed {
        logic [`OB_STOCK_W-1:0]    stock;
        ob_status_e                status;
        logic [`OB_PRICE_W-1:0]    best_bid;
        logic [`OB_PRICE_W-1:0]    best_ask;
        logic [`OB_PRICE_W-1:0]    last_price;
    } ob_result_t;

endpackage

// File: design/order_book_cfg.svh
/* order book dimensions */
`ifndef ORDER_BOOK_CFG_SVH
`define ORDER_BOOK_CFG_SVH

`define OB_NUM_STOCKS 4
`define OB_BOOK_DEPTH 8

`define OB_PRICE_W 32
`define OB_QTY_W   16
`define OB_ID_W    32
`define OB_STOCK_W 2

// slot index and per-stock count, sized for OB_BOOK_DEPTH
`define OB_SLOT_W 3
`define OB_CNT_W  4

`endif
